/* cpu16_core.f */
+incdir+rtl
+incdir+sim
rtl/cpu16_pkg.sv
rtl/pipe_reg.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/hazard_unit.sv
rtl/wb_mem_port.sv
rtl/cpu16_core.sv
sim/tb_cpu16_core.sv

/* Bender.yml */
package:
  name: cpu16_core

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu16_pkg.sv
      - rtl/pipe_reg.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/hazard_unit.sv
      - rtl/wb_mem_port.sv
      - rtl/cpu16_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_cpu16_core.sv

/* sim/cpu16_golden.svh */
`ifndef CPU16_GOLDEN_SVH
`define CPU16_GOLDEN_SVH

logic [15:0] mem_init [256];
logic [15:0] exp_adr [$];
logic [15:0] exp_dat [$];

function automatic logic [15:0] enc_reg(input logic [3:0] op, input int rd, input int rs,
                                        input int rt);
    return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
endfunction

function automatic logic [15:0] enc_imm6(input logic [3:0] op, input int rd, input int rs,
                                         input int imm);
    return {op, rd[2:0], rs[2:0], imm[5:0]};
endfunction

function automatic logic [15:0] enc_imm9(input logic [3:0] op, input int rd, input int imm);
    return {op, rd[2:0], imm[8:0]};
endfunction

// Program at 0, data words at 0x90, store area at 0x80
task automatic load_program();
    for (int i = 0; i < 256; i++)
        mem_init[i] = {i[7:0] ^ 8'ha5, ~i[7:0]};
    mem_init[0]  = enc_imm9(OP_LI, 7, 9'h080);
    mem_init[1]  = enc_imm9(OP_LI, 1, 5);
    mem_init[2]  = enc_imm9(OP_LI, 2, 3);
    mem_init[3]  = enc_reg(OP_ADDU, 3, 1, 2);
    mem_init[4]  = enc_imm6(OP_SW, 3, 7, 0);
    mem_init[5]  = enc_reg(OP_SUBU, 4, 1, 2);
    mem_init[6]  = 16'h0000;
    mem_init[7]  = enc_imm6(OP_SW, 4, 7, 1);
    mem_init[8]  = enc_reg(OP_AND, 5, 1, 2);
    mem_init[9]  = 16'h0000;
    mem_init[10] = 16'h0000;
    mem_init[11] = enc_imm6(OP_SW, 5, 7, 2);
    mem_init[12] = enc_reg(OP_OR, 6, 1, 2);
    mem_init[13] = enc_imm6(OP_ADDIU, 6, 6, -2);
    mem_init[14] = enc_imm6(OP_SW, 6, 7, 3);
    // Load-use on an ALU source, then on store data
    mem_init[15] = enc_imm6(OP_LW, 1, 7, 16);
    mem_init[16] = enc_reg(OP_ADDU, 2, 1, 1);
    mem_init[17] = enc_imm6(OP_SW, 2, 7, 4);
    mem_init[18] = enc_imm6(OP_LW, 3, 7, 17);
    mem_init[19] = enc_imm6(OP_SW, 3, 7, 5);
    // Branches, wrong-path stores in between
    mem_init[20] = enc_imm9(OP_LI, 4, 0);
    mem_init[21] = enc_imm9(OP_BEQZ, 4, 2);
    mem_init[22] = enc_imm6(OP_SW, 4, 7, 6);
    mem_init[23] = enc_imm6(OP_SW, 4, 7, 7);
    mem_init[24] = enc_imm9(OP_BEQZ, 1, 1);
    mem_init[25] = enc_imm6(OP_SW, 1, 7, 8);
    mem_init[26] = enc_imm9(OP_B, 0, 1);
    mem_init[27] = enc_imm6(OP_SW, 1, 7, 9);
    mem_init[28] = enc_imm6(OP_ADDIU, 0, 7, 1);
    mem_init[29] = enc_imm6(OP_SW, 0, 7, 10);
    mem_init[30] = enc_imm6(OP_LW, 5, 7, 18);
    mem_init[31] = enc_imm9(OP_BEQZ, 5, 1);
    mem_init[32] = enc_imm6(OP_SW, 1, 7, 12);
    mem_init[33] = enc_imm6(OP_SW, 5, 7, 11);
    mem_init[34] = enc_imm9(OP_HALT, 0, 0);
    mem_init[35] = enc_imm6(OP_SW, 1, 7, 13);
    mem_init[8'h90] = 16'h1234;
    mem_init[8'h91] = 16'hbeef;
    mem_init[8'h92] = 16'h0000;
endtask

// Instruction-level model, one instruction per step
task automatic run_golden();
    logic [15:0] gm [256];
    logic [15:0] r [8];
    logic [15:0] pc;
    logic [15:0] ins;
    logic [15:0] s6;
    logic [15:0] s9;
    logic [15:0] a;
    int          rd;
    int          rs;
    int          rt;
    bit          done;
    gm = mem_init;
    for (int i = 0; i < 8; i++)
        r[i] = '0;
    pc = '0;
    done = 0;
    for (int step = 0; step < 200 && !done; step++)
    begin
        ins = gm[pc[7:0]];
        rd  = ins[11:9];
        rs  = ins[8:6];
        rt  = ins[5:3];
        s6  = {{10{ins[5]}}, ins[5:0]};
        s9  = {{7{ins[8]}}, ins[8:0]};
        a   = r[rs] + s6;
        pc  = pc + 16'd1;
        case (ins[15:12])
            4'd1:  r[rd] = r[rs] + r[rt];
            4'd2:  r[rd] = r[rs] - r[rt];
            4'd3:  r[rd] = r[rs] & r[rt];
            4'd4:  r[rd] = r[rs] | r[rt];
            4'd5:  r[rd] = a;
            4'd6:  r[rd] = {7'd0, ins[8:0]};
            4'd7:  r[rd] = gm[a[7:0]];
            4'd8:
            begin
                exp_adr.push_back(a);
                exp_dat.push_back(r[rd]);
                gm[a[7:0]] = r[rd];
            end
            4'd9:  if (r[rd] == '0) pc = pc + s9;
            4'd10: pc = pc + s9;
            4'd11: done = 1;
            default: ;
        endcase
    end
endtask

`endif

/* sim/tb_cpu16_core.sv */
`timescale 1ns/10ps

module tb_cpu16_core;
    import cpu16_pkg::*;

    `include "cpu16_golden.svh"

    // 40 instructions x (2 transfers x 5 + 3) = 520, with ample margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic        wb_ack;
    logic        halted;

    logic [15:0] mem [256];
    logic [31:0] rng;
    int          cycles;
    int          delay;
    bit          pending;
    logic        prev_stb;
    logic        prev_ack;
    logic        prev_we;
    logic [15:0] prev_adr;
    logic [15:0] prev_dat;

    cpu16_core dut0 (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .halted(halted)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] expv,
                                   input logic [15:0] actv);
        $display("ERROR at %0t: %s expected %h, got %h", $time, name, expv, actv);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic fail_run(input string msg);
        $display("Failure at %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    ////////////////////
    // Bus checks and slave memory

    always @(negedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            fail_run("timeout, core did not halt in time");
        if (rst_n)
        begin
            assert (wb_cyc || !wb_stb) else fail_run("stb high without cyc");
            if (prev_stb && !prev_ack)
            begin
                assert (wb_adr == prev_adr) else report_mismatch("wb_adr", prev_adr, wb_adr);
                assert (wb_we == prev_we) else report_mismatch("wb_we", prev_we, wb_we);
                assert (wb_dat_w == prev_dat)
                    else report_mismatch("wb_dat_w", prev_dat, wb_dat_w);
            end
            // Cycle after an ack must be idle
            assert (!(prev_ack && wb_cyc)) else fail_run("cyc stayed high after ack");
            assert (!(halted && wb_cyc)) else fail_run("bus cycle started after halt");

            if (wb_ack)
            begin
                wb_ack = 1'b0;
            end
            else if (wb_cyc && wb_stb)
            begin
                if (!pending)
                begin
                    rng     = xorshift(rng);
                    delay   = rng[1:0];
                    pending = 1;
                end
                if (delay == 0)
                begin
                    pending = 0;
                    wb_ack  = 1'b1;
                    if (wb_we)
                    begin
                        assert (exp_adr.size() > 0) else fail_run("store beyond golden list");
                        assert (wb_adr == exp_adr[0])
                            else report_mismatch("wb_adr", exp_adr[0], wb_adr);
                        assert (wb_dat_w == exp_dat[0])
                            else report_mismatch("wb_dat_w", exp_dat[0], wb_dat_w);
                        void'(exp_adr.pop_front());
                        void'(exp_dat.pop_front());
                        mem[wb_adr[7:0]] = wb_dat_w;
                    end
                    else
                    begin
                        wb_dat_r = mem[wb_adr[7:0]];
                    end
                end
                else
                begin
                    delay--;
                end
            end
        end
        prev_stb = wb_stb;
        prev_ack = wb_ack;
        prev_we  = wb_we;
        prev_adr = wb_adr;
        prev_dat = wb_dat_w;
    end

    ////////////////////
    // Main sequence

    initial
    begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_ack   = 1'b0;
        wb_dat_r = '0;
        rng      = 32'heee8c4d7;
        cycles   = 0;
        delay    = 0;
        pending  = 0;
        prev_stb = 1'b0;
        prev_ack = 1'b0;
        prev_we  = 1'b0;
        prev_adr = '0;
        prev_dat = '0;
        load_program();
        mem = mem_init;
        run_golden();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        assert (!halted && !wb_cyc) else fail_run("core not idle after reset");
        while (!halted)
            @(negedge clk);
        // Let the bus settle to catch stray cycles after halt
        repeat (20) @(negedge clk);
        if (exp_adr.size() == 0)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
        begin
            $display("Missing %0d expected stores at halt", exp_adr.size());
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

endmodule

/* rtl/cpu16_core.sv */
`timescale 1ns/10ps
`include "cpu16_config.svh"

module cpu16_core (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [`CPU16_ADDR_W-1:0] wb_adr,
    output logic [`CPU16_WORD_W-1:0] wb_dat_w,
    input  logic [`CPU16_WORD_W-1:0] wb_dat_r,
    input  logic                     wb_ack,
    output logic                     halted
);
    import cpu16_pkg::*;

    word_t    pc;
    if_id_t   if_id_d;
    if_id_t   if_id_q;
    id_exe_t  id_exe_d;
    id_exe_t  id_exe_q;
    exe_mem_t exe_mem_d;
    exe_mem_t exe_mem_q;
    mem_wb_t  mem_wb_d;
    mem_wb_t  mem_wb_q;

    word_t fetch_word;
    word_t data_rword;
    word_t branch_target;
    logic  fetch_done;
    logic  busy;
    logic  rs_used;
    logic  rt_used;
    logic  halt_seen;
    logic  branch_taken;
    logic  pc_keep;
    logic  if_keep;
    logic  if_clear;
    logic  id_keep;
    logic  id_clear;
    logic  exe_keep;
    logic  mem_keep;

    ////////////////////
    // Fetch

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pc <= `CPU16_RESET_PC;
        else if (!pc_keep && branch_taken)
            pc <= branch_target;
        else if (!pc_keep && fetch_done)
            pc <= pc + word_t'(1);
    end

    assign if_id_d = '{pc: pc, instr: fetch_word};

    pipe_reg #(.payload_t(if_id_t)) if_id (
        .clk(clk), .rst_n(rst_n), .keep(if_keep), .clear(if_clear),
        .d(if_id_d), .q(if_id_q)
    );

    ////////////////////
    // Decode and execute

    decode_stage decode0 (
        .clk(clk), .rst_n(rst_n),
        .instr(if_id_q.instr), .pc(if_id_q.pc),
        .wb_en(mem_wb_q.wen), .wb_dest(mem_wb_q.rd), .wb_data(mem_wb_q.result),
        .decoded(id_exe_d),
        .rs_used(rs_used), .rt_used(rt_used), .halt_seen(halt_seen)
    );

    pipe_reg #(.payload_t(id_exe_t)) id_exe (
        .clk(clk), .rst_n(rst_n), .keep(id_keep), .clear(id_clear),
        .d(id_exe_d), .q(id_exe_q)
    );

    execute_stage execute0 (
        .ex(id_exe_q),
        .mem_dest(exe_mem_q.rd), .mem_wen(exe_mem_q.wen),
        .mem_result(exe_mem_q.alu_result),
        .wb_dest(mem_wb_q.rd), .wb_wen(mem_wb_q.wen), .wb_result(mem_wb_q.result),
        .result(exe_mem_d),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    pipe_reg #(.payload_t(exe_mem_t)) exe_mem (
        .clk(clk), .rst_n(rst_n), .keep(exe_keep), .clear(1'b0),
        .d(exe_mem_d), .q(exe_mem_q)
    );

    ////////////////////
    // Memory access and writeback

    // Writeback select, loaded word or ALU result
    assign mem_wb_d = '{
        result: exe_mem_q.load ? data_rword : exe_mem_q.alu_result,
        rd:     exe_mem_q.rd,
        wen:    exe_mem_q.wen,
        halt:   exe_mem_q.halt
    };

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb (
        .clk(clk), .rst_n(rst_n), .keep(mem_keep), .clear(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    wb_mem_port mem_port0 (
        .clk(clk), .rst_n(rst_n),
        .fetch_addr(pc), .fetch_req(!halt_seen),
        .data_read(exe_mem_q.load), .data_write(exe_mem_q.store),
        .data_addr(exe_mem_q.alu_result), .data_wdata(exe_mem_q.store_data),
        .fetch_word(fetch_word), .data_rword(data_rword),
        .fetch_done(fetch_done), .data_done(), .busy(busy),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    hazard_unit hazard0 (
        .id_rs(id_exe_d.rs), .id_rt(id_exe_d.rt),
        .rs_used(rs_used), .rt_used(rt_used),
        .ex_dest(id_exe_q.rd), .ex_load(id_exe_q.load),
        .branch_taken(branch_taken), .busy(busy),
        .id_halt(halt_seen), .wb_halt(mem_wb_q.halt),
        .pc_keep(pc_keep), .if_keep(if_keep), .if_clear(if_clear),
        .id_keep(id_keep), .id_clear(id_clear),
        .exe_keep(exe_keep), .mem_keep(mem_keep),
        .halted(halted)
    );

endmodule

/* rtl/wb_mem_port.sv */
`timescale 1ns/10ps

module wb_mem_port (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu16_pkg::word_t fetch_addr,
    input  logic             fetch_req,
    input  logic             data_read,
    input  logic             data_write,
    input  cpu16_pkg::word_t data_addr,
    input  cpu16_pkg::word_t data_wdata,
    output cpu16_pkg::word_t fetch_word,
    output cpu16_pkg::word_t data_rword,
    output logic             fetch_done,
    output logic             data_done,
    output logic             busy,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output cpu16_pkg::word_t wb_adr,
    output cpu16_pkg::word_t wb_dat_w,
    input  cpu16_pkg::word_t wb_dat_r,
    input  logic             wb_ack
);
    import cpu16_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DATA,
        ST_GAP
    } state_t;

    state_t state;
    logic   data_req;
    logic   data_start;
    logic   f_valid;
    word_t  f_tag;
    logic   d_served;

    assign data_req   = data_read || data_write;
    assign data_start = data_req && !d_served;

    // Fetched word stays valid while the PC points at it
    assign fetch_done = f_valid && (f_tag == fetch_addr);
    assign data_done  = d_served;
    assign busy       = (fetch_req && !fetch_done) || (data_req && !data_done);

    ////////////////////
    // Bus FSM

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= ST_IDLE;
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
            f_valid  <= 1'b0;
            d_served <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    // Data access wins over fetch
                    if (data_start || (fetch_req && !fetch_done))
                    begin
                        state  <= data_start ? ST_DATA : ST_FETCH;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= data_start && data_write;
                    end
                end
                ST_FETCH, ST_DATA:
                begin
                    if (wb_ack)
                    begin
                        state  <= ST_GAP;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase

            if (state == ST_FETCH && wb_ack)
                f_valid <= 1'b1;
            else if (state == ST_DATA && wb_ack && wb_we && wb_adr == f_tag)
                f_valid <= 1'b0;

            // Served data holds until the pipeline moves on
            if (state == ST_DATA && wb_ack)
                d_served <= 1'b1;
            else if (!busy)
                d_served <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE)
        begin
            wb_adr   <= data_start ? data_addr : fetch_addr;
            wb_dat_w <= data_wdata;
        end
        if (state == ST_FETCH && wb_ack)
        begin
            fetch_word <= wb_dat_r;
            f_tag      <= wb_adr;
        end
        if (state == ST_DATA && wb_ack)
            data_rword <= wb_dat_r;
    end

    // Slave sees a steady request until it acks
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we));

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/10ps

module hazard_unit (
    input  cpu16_pkg::reg_idx_t id_rs,
    input  cpu16_pkg::reg_idx_t id_rt,
    input  logic                rs_used,
    input  logic                rt_used,
    input  cpu16_pkg::reg_idx_t ex_dest,
    input  logic                ex_load,
    input  logic                branch_taken,
    input  logic                busy,
    input  logic                id_halt,
    input  logic                wb_halt,
    output logic                pc_keep,
    output logic                if_keep,
    output logic                if_clear,
    output logic                id_keep,
    output logic                id_clear,
    output logic                exe_keep,
    output logic                mem_keep,
    output logic                halted
);

    logic load_use;

    assign load_use = ex_load && ((rs_used && id_rs == ex_dest) ||
                                  (rt_used && id_rt == ex_dest));

    always_comb
    begin
        pc_keep  = 1'b0;
        if_keep  = 1'b0;
        if_clear = 1'b0;
        id_keep  = 1'b0;
        id_clear = 1'b0;
        if (busy)
        begin
            // Memory port not done, freeze everything
            pc_keep = 1'b1;
            if_keep = 1'b1;
            id_keep = 1'b1;
        end
        else if (branch_taken)
        begin
            if_clear = 1'b1;
            id_clear = 1'b1;
        end
        else if (load_use)
        begin
            pc_keep  = 1'b1;
            if_keep  = 1'b1;
            id_clear = 1'b1;
        end
        else if (id_halt)
        begin
            pc_keep = 1'b1;
            if_keep = 1'b1;
        end
    end

    assign exe_keep = busy;
    assign mem_keep = busy;

    // HALT stays parked in decode and refills the later stages,
    // so writeback keeps showing it until reset
    assign halted = wb_halt;

    // Execute holds either a branch or a load, never both
    always_comb
    begin
        flush_vs_bubble: assert final (!(branch_taken === 1'b1 && load_use === 1'b1));
    end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    input  cpu16_pkg::id_exe_t  ex,
    input  cpu16_pkg::reg_idx_t mem_dest,
    input  logic                mem_wen,
    input  cpu16_pkg::word_t    mem_result,
    input  cpu16_pkg::reg_idx_t wb_dest,
    input  logic                wb_wen,
    input  cpu16_pkg::word_t    wb_result,
    output cpu16_pkg::exe_mem_t result,
    output logic                branch_taken,
    output cpu16_pkg::word_t    branch_target
);
    import cpu16_pkg::*;

    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
    word_t    src_a;
    word_t    src_b;
    word_t    opnd_b;
    word_t    alu_out;

    // Nearer stage wins
    function automatic fwd_sel_t pick_src(input reg_idx_t idx, input logic used);
        if (used && mem_wen && mem_dest == idx)
            return FWD_MEM;
        else if (used && wb_wen && wb_dest == idx)
            return FWD_WB;
        return FWD_REG;
    endfunction

    function automatic word_t fwd_value(input fwd_sel_t sel, input word_t reg_val);
        case (sel)
            FWD_MEM: return mem_result;
            FWD_WB:  return wb_result;
            default: return reg_val;
        endcase
    endfunction

    assign sel_a  = pick_src(ex.rs, ex.rs_used);
    assign sel_b  = pick_src(ex.rt, ex.rt_used);
    assign src_a  = fwd_value(sel_a, ex.op_a);
    assign src_b  = fwd_value(sel_b, ex.op_b);
    assign opnd_b = ex.use_imm ? ex.imm : src_b;

    always_comb
    begin
        case (ex.alu_op)
            ALU_ADD: alu_out = src_a + opnd_b;
            ALU_SUB: alu_out = src_a - opnd_b;
            ALU_AND: alu_out = src_a & opnd_b;
            default: alu_out = src_a | opnd_b;
        endcase
    end

    // BEQZ tests operand A, target is relative to pc plus one
    assign branch_taken  = ex.br_always || (ex.br_zero && src_a == '0);
    assign branch_target = ex.pc + word_t'(1) + ex.imm;

    assign result.alu_result = alu_out;
    assign result.store_data = src_b;
    assign result.rd         = ex.rd;
    assign result.wen        = ex.wen;
    assign result.load       = ex.load;
    assign result.store      = ex.store;
    assign result.halt       = ex.halt;

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/10ps
`include "cpu16_config.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu16_pkg::word_t    instr,
    input  cpu16_pkg::word_t    pc,
    input  logic                wb_en,
    input  cpu16_pkg::reg_idx_t wb_dest,
    input  cpu16_pkg::word_t    wb_data,
    output cpu16_pkg::id_exe_t  decoded,
    output logic                rs_used,
    output logic                rt_used,
    output logic                halt_seen
);
    import cpu16_pkg::*;

    word_t    regs [`CPU16_NREGS];
    opcode_t  opcode;
    reg_idx_t f_rd;
    reg_idx_t f_rs;
    reg_idx_t f_rt;
    id_exe_t  ctl;

    assign opcode = opcode_t'(instr[15:12]);
    assign f_rd   = instr[11:9];
    assign f_rs   = instr[8:6];
    assign f_rt   = instr[5:3];

    // Write-first read port
    function automatic word_t rf_read(input reg_idx_t idx);
        return (wb_en && wb_dest == idx) ? wb_data : regs[idx];
    endfunction

    ////////////////////
    // Control decode

    always_comb
    begin
        ctl     = '0;
        ctl.pc  = pc;
        ctl.rs  = f_rs;
        ctl.rt  = f_rt;
        ctl.rd  = f_rd;
        ctl.imm = {{(`CPU16_WORD_W-6){instr[5]}}, instr[5:0]};
        case (opcode)
            OP_ADDU, OP_SUBU, OP_AND, OP_OR:
            begin
                ctl.rs_used = 1'b1;
                ctl.rt_used = 1'b1;
                ctl.wen     = 1'b1;
                // Register ops are numbered in ALU order
                ctl.alu_op  = alu_op_t'(opcode - OP_ADDU);
            end
            OP_ADDIU, OP_LW:
            begin
                ctl.rs_used = 1'b1;
                ctl.use_imm = 1'b1;
                ctl.wen     = 1'b1;
                ctl.load    = (opcode == OP_LW);
            end
            OP_LI:
            begin
                ctl.imm     = {{(`CPU16_WORD_W-9){1'b0}}, instr[8:0]};
                ctl.use_imm = 1'b1;
                ctl.wen     = 1'b1;
            end
            OP_SW:
            begin
                // Store data comes from rd
                ctl.rt      = f_rd;
                ctl.rs_used = 1'b1;
                ctl.rt_used = 1'b1;
                ctl.use_imm = 1'b1;
                ctl.store   = 1'b1;
            end
            OP_BEQZ, OP_B:
            begin
                ctl.imm       = {{(`CPU16_WORD_W-9){instr[8]}}, instr[8:0]};
                ctl.rs        = f_rd;
                ctl.rs_used   = (opcode == OP_BEQZ);
                ctl.br_zero   = (opcode == OP_BEQZ);
                ctl.br_always = (opcode == OP_B);
            end
            OP_HALT:
                ctl.halt = 1'b1;
            default: ;
        endcase
    end

    // Unused operand A reads as zero, LI relies on it
    always_comb
    begin
        decoded      = ctl;
        decoded.op_a = ctl.rs_used ? rf_read(ctl.rs) : '0;
        decoded.op_b = rf_read(ctl.rt);
    end

    assign rs_used   = ctl.rs_used;
    assign rt_used   = ctl.rt_used;
    assign halt_seen = ctl.halt;

    ////////////////////
    // Register file

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU16_NREGS; i++)
                regs[i] <= '0;
        end
        else if (wb_en)
        begin
            regs[wb_dest] <= wb_data;
        end
    end

    // Opcodes above HALT retire as NOPs
    undef_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        (instr[15:12] > OP_HALT) |-> !decoded.wen);

endmodule

/* rtl/pipe_reg.sv */
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     keep,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    // Clear beats keep so a flush lands even during a stall
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            q <= '0;
        else if (clear)
            q <= '0;
        else if (!keep)
            q <= d;
    end

    // A held stage keeps its instruction into the next cycle
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        keep && !clear |=> $stable(q));

endmodule

/* rtl/cpu16_pkg.sv */
`include "cpu16_config.svh"

package cpu16_pkg;

    typedef logic [`CPU16_WORD_W-1:0] word_t;
    typedef logic [$clog2(`CPU16_NREGS)-1:0] reg_idx_t;

    // Instruction bits 15..12
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADDU  = 4'd1,
        OP_SUBU  = 4'd2,
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_ADDIU = 4'd5,
        OP_LI    = 4'd6,
        OP_LW    = 4'd7,
        OP_SW    = 4'd8,
        OP_BEQZ  = 4'd9,
        OP_B     = 4'd10,
        OP_HALT  = 4'd11
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    ////////////////////
    // Stage payloads, all zero is a NOP

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t    pc;
        word_t    op_a;
        word_t    op_b;
        word_t    imm;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     rs_used;
        logic     rt_used;
        alu_op_t  alu_op;
        logic     use_imm;
        logic     wen;
        logic     load;
        logic     store;
        logic     br_zero;
        logic     br_always;
        logic     halt;
    } id_exe_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     wen;
        logic     load;
        logic     store;
        logic     halt;
    } exe_mem_t;

    typedef struct packed {
        word_t    result;
        reg_idx_t rd;
        logic     wen;
        logic     halt;
    } mem_wb_t;

endpackage

/* rtl/cpu16_config.svh */
`ifndef CPU16_CONFIG_SVH
`define CPU16_CONFIG_SVH

// Data and instruction width
`define CPU16_WORD_W 16

// Architectural registers
`define CPU16_NREGS 8

// First fetch address
`define CPU16_RESET_PC 16'h0000

// Wishbone word address width
`define CPU16_ADDR_W 16

`endif
